// File: testbench/loader_patterns.txt
// Test line: id dl_index no_load byte_count inject reset; the first value is the test count
// Byte line: host_addr data write(0 none, 1 internal, 2 external) mem_addr mem_data
5
// ROM image with kernal, BASIC, character set and discarded 1541 bytes
1 00 0 6 0 0
0002 3c 0 0 0
4000 a1 1 e000 a1
7fff b2 1 ffff b2
2003 4d 0 0 0
8010 c3 1 c010 c3
a123 d4 1 8123 d4
// PRG with load address $1001 into internal RAM
2 01 0 5 1 0
0000 01 0 0 0
0001 10 0 0 0
0002 0b 1 1001 0b
0003 10 1 1002 10
0004 0a 1 1003 0a
// PRG with load address $2000 into SDRAM
3 41 0 4 1 0
0000 00 0 0 0
0001 20 0 0 0
0002 55 2 2000 55
0003 aa 2 2001 aa
// Cartridge without load address at $A000
4 01 1 3 1 1
0000 11 2 a000 11
0001 22 2 a001 22
0002 33 2 a002 33
// TAP image
5 81 0 3 0 0
0000 43 2 20000 43
0001 36 2 20001 36
0002 34 2 20002 34

// File: vic20_loader.f
+incdir+src
src/loader_pkg.sv
src/loader_ctrl.sv
src/prg_addr_track.sv
src/reg_inject.sv
src/target_map.sv
src/vic20_loader.sv
testbench/tb_vic20_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_vic20_loader -f vic20_loader.f -o tb_vic20_loader

./obj_dir/tb_vic20_loader > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
exit 1

// File: testbench/tb_vic20_loader.sv
// Reads testbench/loader_patterns.txt relative to the project root; one download per test record
`timescale 1ns/1ns
`default_nettype none

module tb_vic20_loader;

    localparam int MEM_WORDS  = 256;
    localparam int WAIT_LIMIT = 100;
    localparam int IDLE_WATCH = 40;

    logic        clk_sys;
    logic        reset;
    logic        dl_active_i;
    logic [7:0]  dl_index_i;
    logic        dl_wr_i;
    logic [24:0] dl_addr_i;
    logic [7:0]  dl_data_i;
    logic        no_load_addr_i;
    wire  [22:0] mem_addr_o;
    wire  [7:0]  mem_data_o;
    wire         int_we_o;
    wire         ext_we_o;
    wire         force_reset_o;

    logic [31:0] patterns [0:MEM_WORDS-1];
    int          check_errors;
    int          other_errors;
    int          cycle;
    string       cur_name;
    logic [15:0] last_payload;

    vic20_loader UUT (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active_i),
        .dl_index_i     (dl_index_i),
        .dl_wr_i        (dl_wr_i),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .no_load_addr_i (no_load_addr_i),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o),
        .int_we_o       (int_we_o),
        .ext_we_o       (ext_we_o),
        .force_reset_o  (force_reset_o)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // Cycle count used to measure the injection spacing
    always @(posedge clk_sys) begin
        cycle <= cycle + 1;
    end

    // ====================
    // Helpers
    // ====================
    function automatic string test_name(input logic [31:0] id);
        case (id)
            1:       return "rom_regions";
            2:       return "prg_1001_internal";
            3:       return "prg_2000_external";
            4:       return "prg_cart_no_load";
            5:       return "tap_image";
            default: return "unknown_test";
        endcase
    endfunction

    // BASIC zero-page pointers in injection order
    function automatic logic [22:0] pointer_addr(input int n);
        case (n)
            0:       return 23'h00002D;
            1:       return 23'h00002E;
            2:       return 23'h00002F;
            3:       return 23'h000030;
            4:       return 23'h000031;
            5:       return 23'h000032;
            6:       return 23'h0000AE;
            default: return 23'h0000AF;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            check_errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     cur_name, what, expected, actual);
        end
    endtask

    // One host byte, then its result one cycle later
    task automatic send_byte(input logic [24:0] addr, input logic [7:0] data,
                             input logic [1:0] kind, input logic [22:0] exp_addr,
                             input logic [7:0] exp_data);
        @(posedge clk_sys);
        dl_wr_i   <= 1'b1;
        dl_addr_i <= addr;
        dl_data_i <= data;
        @(posedge clk_sys);
        dl_wr_i <= 1'b0;
        @(negedge clk_sys);
        check_value("int_we", 32'(kind == 2'd1), 32'(int_we_o));
        check_value("ext_we", 32'(kind == 2'd2), 32'(ext_we_o));
        if (kind != 2'd0) begin
            check_value("mem_addr", 32'(exp_addr), 32'(mem_addr_o));
            check_value("mem_data", 32'(exp_data), 32'(mem_data_o));
        end
        repeat (2) @(posedge clk_sys);
    endtask

    task automatic check_injection();
        int         n;
        int         waited;
        int         last_cycle;
        logic [7:0] exp_data;
        last_cycle = 0;
        for (n = 0; n < 8; n++) begin
            waited = 0;
            @(negedge clk_sys);
            while (!int_we_o && !ext_we_o && waited < WAIT_LIMIT) begin
                @(negedge clk_sys);
                waited++;
            end
            assert (waited < WAIT_LIMIT) else begin
                other_errors++;
                $display("%s: injected write %0d did not arrive within %0d cycles",
                         cur_name, n, WAIT_LIMIT);
                return;
            end
            // Low byte first, then high byte of the last payload address
            exp_data = n[0] ? last_payload[15:8] : last_payload[7:0];
            check_value("inject int_we", 1, 32'(int_we_o));
            check_value("inject addr", 32'(pointer_addr(n)), 32'(mem_addr_o));
            check_value("inject data", 32'(exp_data), 32'(mem_data_o));
            if (n > 0) begin
                check_value("inject spacing", 2, 32'(cycle - last_cycle));
            end
            last_cycle = cycle;
        end
    endtask

    task automatic check_reset_pulse(input logic expected);
        int waited;
        int pulses;
        int stray;
        waited = 0;
        pulses = 0;
        stray  = 0;
        if (expected) begin
            while (!force_reset_o && waited < WAIT_LIMIT) begin
                @(negedge clk_sys);
                waited++;
            end
            assert (force_reset_o) else begin
                other_errors++;
                $display("%s: reset request did not pulse within %0d cycles",
                         cur_name, WAIT_LIMIT);
                return;
            end
            pulses = 1;
        end
        // Sequencer must go idle with no extra pulse or write
        for (waited = 0; waited < IDLE_WATCH; waited++) begin
            @(negedge clk_sys);
            if (force_reset_o) begin
                pulses++;
            end
            if (int_we_o || ext_we_o) begin
                stray++;
            end
        end
        check_value("force_reset pulses", 32'(expected), pulses);
        check_value("stray writes", 0, stray);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int   ntests;
        int   ptr;
        int   t;
        int   b;
        int   nbytes;
        logic inject;
        logic want_reset;
        reset          = 1'b1;
        dl_active_i    = 1'b0;
        dl_index_i     = 8'h00;
        dl_wr_i        = 1'b0;
        dl_addr_i      = '0;
        dl_data_i      = 8'h00;
        no_load_addr_i = 1'b0;
        check_errors   = 0;
        other_errors   = 0;
        last_payload   = 16'h0000;
        cur_name       = "reset";
        $readmemh("testbench/loader_patterns.txt", patterns);

        repeat (8) @(posedge clk_sys);
        reset <= 1'b0;
        @(negedge clk_sys);
        check_value("int_we", 0, 32'(int_we_o));
        check_value("ext_we", 0, 32'(ext_we_o));
        check_value("force_reset", 0, 32'(force_reset_o));
        check_value("inj_step", 0, 32'(UUT.inj_step));

        ntests = 0;
        if ($isunknown(patterns[0]) || patterns[0] == 0) begin
            other_errors++;
            $display("Pattern file is missing or holds no tests");
        end else begin
            ntests = int'(patterns[0]);
        end

        ptr = 1;
        for (t = 0; t < ntests; t++) begin
            cur_name   = test_name(patterns[ptr]);
            nbytes     = int'(patterns[ptr+3]);
            inject     = patterns[ptr+4][0];
            want_reset = patterns[ptr+5][0];
            @(posedge clk_sys);
            dl_index_i     <= patterns[ptr+1][7:0];
            no_load_addr_i <= patterns[ptr+2][0];
            dl_active_i    <= 1'b1;
            ptr += 6;
            for (b = 0; b < nbytes; b++) begin
                send_byte(patterns[ptr][24:0], patterns[ptr+1][7:0], patterns[ptr+2][1:0],
                          patterns[ptr+3][22:0], patterns[ptr+4][7:0]);
                if (patterns[ptr+2][1:0] != 2'd0) begin
                    last_payload = patterns[ptr+3][15:0];
                end
                ptr += 5;
            end
            @(posedge clk_sys);
            dl_active_i <= 1'b0;
            if (inject) begin
                check_injection();
            end
            check_reset_pulse(want_reset);
        end

        $display("Checks failed: %0d, other errors: %0d", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/vic20_loader.sv
// One host byte per cycle at most; memory writes appear one cycle after their host strobe
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module vic20_loader import loader_pkg::*; (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire                         dl_active_i,
    input  wire [`LDR_INDEX_W-1:0]      dl_index_i,
    input  wire                         dl_wr_i,
    input  wire [`LDR_HOST_ADDR_W-1:0]  dl_addr_i,
    input  wire [`LDR_DATA_W-1:0]       dl_data_i,
    input  wire                         no_load_addr_i,
    output wire [`LDR_TARGET_W-1:0]     mem_addr_o,
    output wire [`LDR_DATA_W-1:0]       mem_data_o,
    output wire                         int_we_o,
    output wire                         ext_we_o,
    output wire                         force_reset_o
);

    dl_kind_t                   kind;
    inj_step_t                  inj_step;
    wire                        prg_wr;
    wire                        tap_wr;
    wire                        rom_wr;
    wire [`LDR_CPU_ADDR_W-1:0]  prg_addr;
    wire                        prg_payload;
    wire                        at_cart;
    wire [`LDR_CPU_ADDR_W-1:0]  inj_addr;
    wire [`LDR_DATA_W-1:0]      inj_data;
    wire                        inj_wr;

    loader_ctrl u_ctrl (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .dl_active_i   (dl_active_i),
        .dl_index_i    (dl_index_i),
        .dl_wr_i       (dl_wr_i),
        .at_cart_i     (at_cart),
        .prg_payload_i (prg_payload),
        .kind_o        (kind),
        .prg_wr_o      (prg_wr),
        .tap_wr_o      (tap_wr),
        .rom_wr_o      (rom_wr),
        .inj_step_o    (inj_step),
        .force_reset_o (force_reset_o)
    );

    prg_addr_track u_prg (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .prg_wr_i       (prg_wr),
        .no_load_addr_i (no_load_addr_i),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .prg_addr_o     (prg_addr),
        .prg_payload_o  (prg_payload),
        .at_cart_o      (at_cart)
    );

    reg_inject u_inject (
        .inj_step_i (inj_step),
        .prg_addr_i (prg_addr),
        .inj_addr_o (inj_addr),
        .inj_data_o (inj_data),
        .inj_wr_o   (inj_wr)
    );

    target_map u_map (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .kind_i        (kind),
        .rom_wr_i      (rom_wr),
        .tap_wr_i      (tap_wr),
        .prg_payload_i (prg_payload),
        .dl_addr_i     (dl_addr_i),
        .dl_data_i     (dl_data_i),
        .prg_addr_i    (prg_addr),
        .inj_addr_i    (inj_addr),
        .inj_data_i    (inj_data),
        .inj_wr_i      (inj_wr),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o),
        .int_we_o      (int_we_o),
        .ext_we_o      (ext_we_o)
    );

endmodule

`default_nettype wire

// File: src/target_map.sv
// ROM offsets 1541 and above $C000 are dropped; injected pointer writes always go internal
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module target_map import loader_pkg::*; (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire dl_kind_t               kind_i,
    input  wire                         rom_wr_i,
    input  wire                         tap_wr_i,
    input  wire                         prg_payload_i,
    input  wire [`LDR_HOST_ADDR_W-1:0]  dl_addr_i,
    input  wire [`LDR_DATA_W-1:0]       dl_data_i,
    input  wire [`LDR_CPU_ADDR_W-1:0]   prg_addr_i,
    input  wire [`LDR_CPU_ADDR_W-1:0]   inj_addr_i,
    input  wire [`LDR_DATA_W-1:0]       inj_data_i,
    input  wire                         inj_wr_i,
    output logic [`LDR_TARGET_W-1:0]    mem_addr_o,
    output logic [`LDR_DATA_W-1:0]      mem_data_o,
    output logic                        int_we_o,
    output logic                        ext_we_o
);

    logic [`LDR_TARGET_W-1:0] tap_addr_q;
    logic [`LDR_TARGET_W-1:0] tap_next;
    logic [`LDR_TARGET_W-1:0] rom_addr;
    logic [`LDR_TARGET_W-1:0] target;
    logic                     rom_valid;
    logic                     prg_internal;
    logic                     wr_int;
    logic                     wr_ext;

    // Tape image restarts at its base on host byte 0
    assign tap_next = (dl_addr_i == '0) ? {1'b0, `LDR_TAP_START} : tap_addr_q + 23'd1;

    // ====================
    // ROM region map
    // ====================
    always_comb begin
        rom_valid = 1'b1;
        case (dl_addr_i[15:13])
            // Kernal, PAL and NTSC images share $E000
            3'b010,
            3'b011:  rom_addr = {7'h0, 3'b111, dl_addr_i[12:0]};
            // BASIC
            3'b100:  rom_addr = {7'h0, 3'b110, dl_addr_i[12:0]};
            // Character set, 4K
            3'b101:  rom_addr = {7'h0, 4'b1000, dl_addr_i[11:0]};
            default: begin
                rom_addr  = '0;
                rom_valid = 1'b0;
            end
        endcase
    end

    // Low RAM, main RAM and colour RAM live inside the machine
    assign prg_internal = (prg_addr_i[15:10] == 6'b000000) ||
                          (prg_addr_i[15:12] == 4'b0001) ||
                          (prg_addr_i[15:10] == 6'b100101);

    // ====================
    // Target select and split
    // ====================
    always_comb begin
        target = {7'h0, prg_addr_i};
        wr_int = 1'b0;
        wr_ext = 1'b0;
        if (inj_wr_i) begin
            target = {7'h0, inj_addr_i};
            wr_int = 1'b1;
        end else begin
            case (kind_i)
                DL_ROM: begin
                    target = rom_addr;
                    wr_int = rom_wr_i && rom_valid;
                end
                DL_PRG: begin
                    wr_int = prg_payload_i && prg_internal;
                    wr_ext = prg_payload_i && !prg_internal;
                end
                DL_TAP: begin
                    target = tap_next;
                    wr_ext = tap_wr_i;
                end
                default: begin
                    wr_int = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            int_we_o   <= 1'b0;
            ext_we_o   <= 1'b0;
            tap_addr_q <= {1'b0, `LDR_TAP_START};
        end else begin
            int_we_o <= wr_int;
            ext_we_o <= wr_ext;
            if (tap_wr_i) begin
                tap_addr_q <= tap_next;
            end
        end
    end

    // Address and data hold the last write
    always_ff @(posedge clk_sys) begin
        if (wr_int || wr_ext) begin
            mem_addr_o <= target;
            mem_data_o <= inj_wr_i ? inj_data_i : dl_data_i;
        end
    end

    // An injected pointer write would hide a host byte on the same cycle
    a_we_excl: assert property (@(posedge clk_sys) disable iff (reset)
        !(inj_wr_i && (rom_wr_i || tap_wr_i || prg_payload_i)));

endmodule

`default_nettype wire

// File: src/reg_inject.sv
// Pointer table follows the stock VIC-20 BASIC zero page; all entries point to the program end
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module reg_inject import loader_pkg::*; (
    input  wire inj_step_t              inj_step_i,
    input  wire [`LDR_CPU_ADDR_W-1:0]   prg_addr_i,
    output logic [`LDR_CPU_ADDR_W-1:0]  inj_addr_o,
    output logic [`LDR_DATA_W-1:0]      inj_data_o,
    output logic                        inj_wr_o
);

    // ====================
    // Pointer table
    // ====================
    always_comb begin
        inj_addr_o = '0;
        inj_wr_o   = 1'b1;
        case (inj_step_i)
            // Start of variables
            5'd1:    inj_addr_o = 16'h002D;
            5'd3:    inj_addr_o = 16'h002E;
            // Start of arrays
            5'd5:    inj_addr_o = 16'h002F;
            5'd7:    inj_addr_o = 16'h0030;
            // End of arrays
            5'd9:    inj_addr_o = 16'h0031;
            5'd11:   inj_addr_o = 16'h0032;
            // End address of the last load
            5'd13:   inj_addr_o = 16'h00AE;
            5'd15:   inj_addr_o = 16'h00AF;
            default: inj_wr_o   = 1'b0;
        endcase
    end

    // Steps 3, 7, 11 and 15 take the high byte
    assign inj_data_o = inj_step_i[1] ? prg_addr_i[15:8] : prg_addr_i[7:0];

endmodule

`default_nettype wire

// File: src/prg_addr_track.sv
// Header mode expects the load address in host bytes 0 and 1; the address wraps at $FFFF
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module prg_addr_track (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire                         prg_wr_i,
    input  wire                         no_load_addr_i,
    input  wire [`LDR_HOST_ADDR_W-1:0]  dl_addr_i,
    input  wire [`LDR_DATA_W-1:0]       dl_data_i,
    output logic [`LDR_CPU_ADDR_W-1:0]  prg_addr_o,
    output logic                        prg_payload_o,
    output logic                        at_cart_o
);

    // Host offsets of the load-address header and the first payload byte
    localparam logic [`LDR_HOST_ADDR_W-1:0] HOST_LO    = 0;
    localparam logic [`LDR_HOST_ADDR_W-1:0] HOST_HI    = 1;
    localparam logic [`LDR_HOST_ADDR_W-1:0] HOST_FIRST = 2;

    logic [`LDR_CPU_ADDR_W-1:0] addr_q;
    logic [`LDR_CPU_ADDR_W-1:0] addr_next;

    // Address for the byte on the bus this cycle
    always_comb begin
        addr_next = addr_q + 16'd1;
        if (no_load_addr_i) begin
            if (dl_addr_i == HOST_LO) begin
                addr_next = `LDR_CART_ADDR;
            end
        end else begin
            if (dl_addr_i == HOST_LO) begin
                addr_next = {addr_q[15:8], dl_data_i};
            end else if (dl_addr_i == HOST_HI) begin
                addr_next = {dl_data_i, addr_q[7:0]};
            end else if (dl_addr_i == HOST_FIRST) begin
                addr_next = addr_q;
            end
        end
    end

    // Header bytes carry no program data
    assign prg_payload_o = prg_wr_i && (no_load_addr_i || dl_addr_i > HOST_HI);

    // Between bytes this holds the last payload address
    assign prg_addr_o = prg_wr_i ? addr_next : addr_q;
    assign at_cart_o  = (prg_addr_o == `LDR_CART_ADDR);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            addr_q <= '0;
        end else if (prg_wr_i) begin
            addr_q <= addr_next;
        end
    end

endmodule

`default_nettype wire

// File: src/loader_ctrl.sv
// Host must keep dl_active_i low until injection ends; unknown index codes are ignored
`timescale 1ns/1ns
`default_nettype none
`include "loader_settings.svh"

module loader_ctrl import loader_pkg::*; (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  wire                     dl_active_i,
    input  wire [`LDR_INDEX_W-1:0]  dl_index_i,
    input  wire                     dl_wr_i,
    input  wire                     at_cart_i,
    input  wire                     prg_payload_i,
    output dl_kind_t                kind_o,
    output logic                    prg_wr_o,
    output logic                    tap_wr_o,
    output logic                    rom_wr_o,
    output inj_step_t               inj_step_o,
    output logic                    force_reset_o
);

    dl_kind_t kind_dec;
    logic     prg_q;
    logic     prg_end;
    logic     auto_reset;

    // ====================
    // Download kind decode
    // ====================
    always_comb begin
        kind_dec = DL_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                `LDR_IDX_ROM: kind_dec = DL_ROM;
                `LDR_IDX_PRG,
                `LDR_IDX_CRT: kind_dec = DL_PRG;
                `LDR_IDX_TAP: kind_dec = DL_TAP;
                default:      kind_dec = DL_NONE;
            endcase
        end
    end

    assign kind_o = kind_dec;

    // One byte strobe per kind
    assign rom_wr_o = dl_wr_i && (kind_dec == DL_ROM);
    assign prg_wr_o = dl_wr_i && (kind_dec == DL_PRG);
    assign tap_wr_o = dl_wr_i && (kind_dec == DL_TAP);

    // PRG download just finished
    assign prg_end = prg_q && (kind_dec != DL_PRG);

    // ====================
    // Injection sequencer
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_q         <= 1'b0;
            inj_step_o    <= '0;
            auto_reset    <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            prg_q         <= (kind_dec == DL_PRG);
            force_reset_o <= 1'b0;

            // Cartridge image seen at its fixed address
            if (prg_payload_i && at_cart_i) begin
                auto_reset <= 1'b1;
            end

            // Counter runs freely once started and wraps to idle after the last step
            if (prg_end) begin
                inj_step_o <= 5'd1;
            end else if (inj_step_o != '0) begin
                inj_step_o <= inj_step_o + 5'd1;
            end

            if (inj_step_o == `LDR_INJECT_LAST) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
        end
    end

    // ====================
    // Checks
    // ====================

    // Odd steps are injected writes, so they must not meet a host byte
    a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
        $onehot0({rom_wr_o, prg_wr_o, tap_wr_o, inj_step_o[0]}));

    // A new download may only start once injection is back at idle
    a_step_hold: assert property (@(posedge clk_sys) disable iff (reset)
        dl_active_i |=> $stable(inj_step_o));

endmodule

`default_nettype wire

// File: src/loader_pkg.sv
// Types shared by the loader RTL; download kind NONE also covers unknown host index codes
`default_nettype none

package loader_pkg;

    // ====================
    // Download kinds
    // ====================

    // Kind of the download in progress
    typedef enum logic [1:0] {
        DL_NONE = 2'd0,
        DL_ROM  = 2'd1,
        DL_PRG  = 2'd2,
        DL_TAP  = 2'd3
    } dl_kind_t;

    // ====================
    // Register injection
    // ====================

    // Step 0 is idle, odd steps 1 to 15 write a pointer byte,
    // the last step may raise the reset request
    typedef logic [4:0] inj_step_t;

endpackage

`default_nettype wire

// File: src/loader_settings.svh
// Widths assume 25-bit host offsets, a 16-bit CPU bus and SDRAM seen as a 23-bit byte space
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// ====================
// Bus widths
// ====================
`define LDR_HOST_ADDR_W 25
`define LDR_TARGET_W    23
`define LDR_CPU_ADDR_W  16
`define LDR_DATA_W      8
`define LDR_INDEX_W     8

// ====================
// Download index codes from the host menu
// ====================
`define LDR_IDX_ROM     8'h00
`define LDR_IDX_PRG     8'h01
`define LDR_IDX_CRT     8'h41
`define LDR_IDX_TAP     8'h81

// ====================
// Memory bases and injection timing
// ====================
`define LDR_TAP_START   22'h20000
`define LDR_CART_ADDR   16'hA000
`define LDR_INJECT_LAST 5'd31

`endif
